//--- hw/prf_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Integer physical register file definitions for the busy table:
// register index and mask widths, set and clear requests, issue slot
// sources and the per-slot operand status
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package prf_pkg;

  // 64 integer physical registers
  localparam int prf_index_w = 6;
  localparam int prf_size    = 1 << prf_index_w;

  typedef logic [prf_index_w-1:0] prf_index_t;

  // One bit per physical register
  typedef logic [prf_size-1:0] prf_mask_t;

  // Dispatch destination or write-back destination
  typedef struct packed {
    logic       valid;
    prf_index_t index;
  } busy_req_t;

  // Source operands of one issue queue slot
  typedef struct packed {
    prf_index_t rs1_index;
    prf_index_t rs2_index;
    logic       rs1_used;
    logic       rs2_used;
  } uop_srcs_t;

  // Answer returned to one issue queue slot
  typedef struct packed {
    logic rs1_busy;
    logic rs2_busy;
    logic ready;
  } src_status_t;

endpackage

`default_nettype wire

//--- hw/busy_update_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// busy_update_decode: folds the per-way set and clear requests into
// one-hot masks over all physical registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module busy_update_decode #(
  parameter int WAYS = 2
) (
  // Dispatch destinations
  input  prf_pkg::busy_req_t [WAYS-1:0] set_req,
  // Write-back destinations
  input  prf_pkg::busy_req_t [WAYS-1:0] clr_req,
  output prf_pkg::prf_mask_t            set_mask,
  output prf_pkg::prf_mask_t            clr_mask
);

  // One-hot decode of a single request, all zero when not valid
  function automatic prf_pkg::prf_mask_t req_onehot(input prf_pkg::busy_req_t req);
    prf_pkg::prf_mask_t mask;
    mask = '0;
    if (req.valid) begin
      mask[req.index] = 1'b1;
    end
    return mask;
  endfunction

  prf_pkg::prf_mask_t set_any;
  prf_pkg::prf_mask_t clr_any;

  // OR together the decodes of every way
  always_comb begin
    set_any = '0;
    clr_any = '0;
    for (int w = 0; w < WAYS; w++) begin
      set_any = set_any | req_onehot(set_req[w]);
      clr_any = clr_any | req_onehot(clr_req[w]);
    end
  end

  // x0 is hardwired to zero and never waits on a producer,
  // so its set bit is dropped here and nowhere else
  always_comb begin
    set_mask    = set_any;
    set_mask[0] = 1'b0;
  end

  // Clearing x0 is harmless, the bit is always zero anyway
  assign clr_mask = clr_any;

endmodule

`default_nettype wire

//--- hw/busy_scoreboard.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// busy_scoreboard: replicated busy bit banks, one per read way, with
// mask update, flush and same-cycle write-back bypass on lookups
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module busy_scoreboard #(
  parameter int WAYS = 2
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           flush,
  // Decoded update masks
  input  prf_pkg::prf_mask_t             set_mask,
  input  prf_pkg::prf_mask_t             clr_mask,
  // Raw write-back requests for the bypass compare
  input  prf_pkg::busy_req_t [WAYS-1:0]  clr_req,
  // Lookups from the issue queue slots
  input  prf_pkg::prf_index_t [WAYS-1:0] rs1_index,
  input  prf_pkg::prf_index_t [WAYS-1:0] rs2_index,
  output logic [WAYS-1:0]                rs1_busy,
  output logic [WAYS-1:0]                rs2_busy
);

  // One bank per read way keeps the read fan-out of each bank at two
  prf_pkg::prf_mask_t bank [WAYS];

  // Every bank sees the same next value
  prf_pkg::prf_mask_t bank_next [WAYS];

  // True when a valid write-back this cycle targets the given register
  function automatic logic clr_hit(
    input prf_pkg::prf_index_t            index,
    input prf_pkg::busy_req_t [WAYS-1:0]  reqs
  );
    logic hit;
    hit = 1'b0;
    for (int j = 0; j < WAYS; j++) begin
      if (reqs[j].valid && (reqs[j].index == index)) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // Clear is applied after set, so a same-cycle set and clear leaves it free
  always_comb begin
    for (int b = 0; b < WAYS; b++) begin
      bank_next[b] = (bank[b] | set_mask) & ~clr_mask;
    end
  end

  // State register; flush discards any set in the same cycle
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      for (int b = 0; b < WAYS; b++) begin
        bank[b] <= '0;
      end
    end else begin
      for (int b = 0; b < WAYS; b++) begin
        bank[b] <= bank_next[b];
      end
    end
  end

  // Lookups, each way reads its own bank
  always_comb begin
    for (int i = 0; i < WAYS; i++) begin
      rs1_busy[i] = bank[i][rs1_index[i]];
      rs2_busy[i] = bank[i][rs2_index[i]];
      // A write-back this cycle wins over the stored bit
      if (clr_hit(rs1_index[i], clr_req)) begin
        rs1_busy[i] = 1'b0;
      end
      if (clr_hit(rs2_index[i], clr_req)) begin
        rs2_busy[i] = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/operand_ready.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// operand_ready: per-slot source busy status and readiness for the
// issue queue
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module operand_ready #(
  parameter int WAYS = 2
) (
  input  prf_pkg::uop_srcs_t   [WAYS-1:0] srcs,
  input  logic                 [WAYS-1:0] rs1_busy,
  input  logic                 [WAYS-1:0] rs2_busy,
  output prf_pkg::src_status_t [WAYS-1:0] status
);

  // A source only blocks its slot when the instruction reads it
  logic [WAYS-1:0] rs1_blocks;
  logic [WAYS-1:0] rs2_blocks;

  for (genvar w = 0; w < WAYS; w++) begin : g_slot

    assign rs1_blocks[w] = srcs[w].rs1_used & rs1_busy[w];
    assign rs2_blocks[w] = srcs[w].rs2_used & rs2_busy[w];

    // Raw busy bits go back unmasked, the slot may track them itself
    assign status[w].rs1_busy = rs1_busy[w];
    assign status[w].rs2_busy = rs2_busy[w];

    // Ready once no used source is still waiting on a write-back
    assign status[w].ready = ~(rs1_blocks[w] | rs2_blocks[w]);

  end

endmodule

`default_nettype wire

//--- hw/busy_table_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// busy_table_top: integer PRF busy table, request decode, banked
// scoreboard and operand readiness
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module busy_table_top #(
  parameter int WAYS = 2
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            flush,
  input  prf_pkg::busy_req_t   [WAYS-1:0] set_req,
  input  prf_pkg::busy_req_t   [WAYS-1:0] clr_req,
  input  prf_pkg::uop_srcs_t   [WAYS-1:0] srcs,
  output prf_pkg::src_status_t [WAYS-1:0] status
);

  prf_pkg::prf_mask_t             set_mask;
  prf_pkg::prf_mask_t             clr_mask;
  prf_pkg::prf_index_t [WAYS-1:0] rs1_index;
  prf_pkg::prf_index_t [WAYS-1:0] rs2_index;
  logic                [WAYS-1:0] rs1_busy;
  logic                [WAYS-1:0] rs2_busy;

  // Source indices for the scoreboard lookups
  for (genvar w = 0; w < WAYS; w++) begin : g_idx
    assign rs1_index[w] = srcs[w].rs1_index;
    assign rs2_index[w] = srcs[w].rs2_index;
  end

  busy_update_decode #(.WAYS(WAYS)) u_decode (
    .set_req  (set_req),
    .clr_req  (clr_req),
    .set_mask (set_mask),
    .clr_mask (clr_mask)
  );

  busy_scoreboard #(.WAYS(WAYS)) u_scoreboard (
    .clk       (clk),
    .rst       (rst),
    .flush     (flush),
    .set_mask  (set_mask),
    .clr_mask  (clr_mask),
    .clr_req   (clr_req),
    .rs1_index (rs1_index),
    .rs2_index (rs2_index),
    .rs1_busy  (rs1_busy),
    .rs2_busy  (rs2_busy)
  );

  operand_ready #(.WAYS(WAYS)) u_ready (
    .srcs     (srcs),
    .rs1_busy (rs1_busy),
    .rs2_busy (rs2_busy),
    .status   (status)
  );

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset generator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Reset drops just after the last reset edge
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

//--- testbench/busy_table_assertions.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Concurrent checks on the replicated busy banks of the scoreboard
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module busy_table_assertions #(
  parameter int WAYS = 2
) (
  input logic               clk,
  input logic               rst,
  input logic               flush,
  input prf_pkg::prf_mask_t set_mask,
  input prf_pkg::prf_mask_t clr_mask,
  input prf_pkg::prf_mask_t bank [WAYS]
);

  // Number of failed checks so far
  int fail_count = 0;

  // Replicas follow bank 0 after every update
  for (genvar b = 1; b < WAYS; b++) begin : g_replica

    a_banks_equal: assert property (@(posedge clk) disable iff (rst)
      (|set_mask || |clr_mask) |=> (bank[b] == bank[0]))
      else begin
        fail_count++;
        $error("bank %0d differs from bank 0 after an update", b);
      end

  end

  for (genvar b = 0; b < WAYS; b++) begin : g_bank

    a_zero_after_clear: assert property (@(posedge clk)
      (rst || flush) |=> (bank[b] == '0))
      else begin
        fail_count++;
        $error("bank %0d not zero after reset or flush", b);
      end

    // x0 never waits on a producer
    a_x0_free: assert property (@(posedge clk) disable iff (rst) !bank[b][0])
      else begin
        fail_count++;
        $error("bank %0d has register 0 marked busy", b);
      end

  end

endmodule

`default_nettype wire

//--- testbench/busy_table_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Busy table testbench: directed step table, LFSR random phase,
// reference model of the busy bits and per-test report
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module busy_table_tb;

  localparam int          WAYS       = 2;
  localparam int          CLK_PERIOD = 40;
  localparam int          RST_CYCLES = 16;
  localparam int          N_DIRECTED = 11;
  localparam int          N_RANDOM   = 200;
  localparam logic [31:0] LFSR_SEED  = 32'h8fd2_c7cb;
  localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;

  typedef prf_pkg::src_status_t [WAYS-1:0] status_vec_t;

  // One cycle of stimulus
  typedef struct packed {
    prf_pkg::busy_req_t [WAYS-1:0] set_req;
    prf_pkg::busy_req_t [WAYS-1:0] clr_req;
    logic                          flush;
    prf_pkg::uop_srcs_t [WAYS-1:0] srcs;
  } step_t;

  logic                          clk;
  logic                          rst;
  logic                          flush;
  prf_pkg::busy_req_t [WAYS-1:0] set_req;
  prf_pkg::busy_req_t [WAYS-1:0] clr_req;
  prf_pkg::uop_srcs_t [WAYS-1:0] srcs;
  status_vec_t                   status;

  step_t              step_table [N_DIRECTED];
  string              step_name [N_DIRECTED];
  prf_pkg::prf_mask_t model_busy;
  logic [31:0]        lfsr_state;
  int                 n_pass;
  int                 n_fail;

  tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RST_CYCLES)) u_clock (
    .clk (clk),
    .rst (rst)
  );

  busy_table_top #(.WAYS(WAYS)) DUT (
    .clk     (clk),
    .rst     (rst),
    .flush   (flush),
    .set_req (set_req),
    .clr_req (clr_req),
    .srcs    (srcs),
    .status  (status)
  );

  bind busy_scoreboard busy_table_assertions #(.WAYS(WAYS)) u_assertions (
    .clk      (clk),
    .rst      (rst),
    .flush    (flush),
    .set_mask (set_mask),
    .clr_mask (clr_mask),
    .bank     (bank)
  );

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[30:0], lfsr_state[0]};
      lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? LFSR_TAPS : 32'h0);
    end
    return bits;
  endfunction

  function automatic prf_pkg::busy_req_t busy_req(input logic v, input int idx);
    prf_pkg::busy_req_t r;
    r.valid = v;
    r.index = prf_pkg::prf_index_t'(idx);
    return r;
  endfunction

  function automatic prf_pkg::uop_srcs_t slot_srcs(input int r1, input int r2,
                                                   input logic u1, input logic u2);
    prf_pkg::uop_srcs_t s;
    s.rs1_index = prf_pkg::prf_index_t'(r1);
    s.rs2_index = prf_pkg::prf_index_t'(r2);
    s.rs1_used  = u1;
    s.rs2_used  = u2;
    return s;
  endfunction

  function automatic step_t make_step(
    input prf_pkg::busy_req_t s0, input prf_pkg::busy_req_t s1,
    input prf_pkg::busy_req_t c0, input prf_pkg::busy_req_t c1,
    input logic fl, input prf_pkg::uop_srcs_t q0, input prf_pkg::uop_srcs_t q1
  );
    step_t st;
    st.set_req[0] = s0;
    st.set_req[1] = s1;
    st.clr_req[0] = c0;
    st.clr_req[1] = c1;
    st.flush      = fl;
    st.srcs[0]    = q0;
    st.srcs[1]    = q1;
    return st;
  endfunction

  task automatic fill_table();
    prf_pkg::busy_req_t none;
    none = busy_req(1'b0, 0);
    step_name[0]  = "idle_after_reset";
    step_table[0] = make_step(none, none, none, none, 1'b0,
                              slot_srcs(5, 9, 1, 1), slot_srcs(0, 63, 1, 1));
    step_name[1]  = "set_p5_way0";
    step_table[1] = make_step(busy_req(1, 5), none, none, none, 1'b0,
                              slot_srcs(5, 5, 1, 1), slot_srcs(5, 0, 1, 0));
    // Register 5 busy on both ways, plus a set to x0
    step_name[2]  = "p5_busy_both_ways";
    step_table[2] = make_step(none, busy_req(1, 0), none, none, 1'b0,
                              slot_srcs(5, 3, 1, 1), slot_srcs(2, 5, 1, 1));
    step_name[3]  = "x0_never_busy";
    step_table[3] = make_step(none, none, none, none, 1'b0,
                              slot_srcs(0, 0, 1, 1), slot_srcs(0, 5, 1, 0));
    step_name[4]  = "clr_p5_bypass";
    step_table[4] = make_step(busy_req(1, 7), busy_req(1, 8), none, busy_req(1, 5), 1'b0,
                              slot_srcs(5, 5, 1, 1), slot_srcs(7, 5, 1, 1));
    step_name[5]  = "p5_stays_free";
    step_table[5] = make_step(none, none, none, none, 1'b0,
                              slot_srcs(5, 7, 1, 1), slot_srcs(8, 5, 1, 1));
    step_name[6]  = "set_clr_same_p9";
    step_table[6] = make_step(busy_req(1, 9), none, busy_req(1, 9), none, 1'b0,
                              slot_srcs(9, 0, 1, 0), slot_srcs(9, 9, 1, 1));
    step_name[7]  = "p9_not_busy";
    step_table[7] = make_step(none, none, none, none, 1'b0,
                              slot_srcs(9, 8, 1, 0), slot_srcs(9, 9, 1, 1));
    step_name[8]  = "unused_busy_ready";
    step_table[8] = make_step(none, none, none, none, 1'b0,
                              slot_srcs(7, 8, 0, 0), slot_srcs(7, 0, 1, 1));
    step_name[9]  = "flush_with_set";
    step_table[9] = make_step(busy_req(1, 12), none, none, none, 1'b1,
                              slot_srcs(7, 8, 1, 1), slot_srcs(12, 0, 1, 1));
    step_name[10]  = "after_flush";
    step_table[10] = make_step(none, none, none, none, 1'b0,
                               slot_srcs(7, 8, 1, 1), slot_srcs(12, 0, 1, 1));
  endtask

  // Small index range so that sets, clears and lookups collide often
  function automatic step_t random_step();
    step_t st;
    for (int w = 0; w < WAYS; w++) begin
      st.set_req[w].valid    = 1'(draw_bits(1));
      st.set_req[w].index    = prf_pkg::prf_index_t'(draw_bits(4));
      st.clr_req[w].valid    = 1'(draw_bits(1));
      st.clr_req[w].index    = prf_pkg::prf_index_t'(draw_bits(4));
      st.srcs[w].rs1_index   = prf_pkg::prf_index_t'(draw_bits(4));
      st.srcs[w].rs2_index   = prf_pkg::prf_index_t'(draw_bits(4));
      st.srcs[w].rs1_used    = 1'(draw_bits(1));
      st.srcs[w].rs2_used    = 1'(draw_bits(1));
    end
    st.flush = (draw_bits(5) == 32'd0);
    return st;
  endfunction

  function automatic logic written_back(input prf_pkg::prf_index_t idx,
                                        input prf_pkg::busy_req_t [WAYS-1:0] clr);
    logic hit;
    hit = 1'b0;
    for (int w = 0; w < WAYS; w++) begin
      hit = hit | (clr[w].valid & (clr[w].index == idx));
    end
    return hit;
  endfunction

  function automatic status_vec_t expected_status(input step_t st);
    status_vec_t exp_st;
    logic        b1;
    logic        b2;
    for (int w = 0; w < WAYS; w++) begin
      b1 = model_busy[st.srcs[w].rs1_index] & ~written_back(st.srcs[w].rs1_index, st.clr_req);
      b2 = model_busy[st.srcs[w].rs2_index] & ~written_back(st.srcs[w].rs2_index, st.clr_req);
      exp_st[w].rs1_busy = b1;
      exp_st[w].rs2_busy = b2;
      exp_st[w].ready    = !((st.srcs[w].rs1_used && b1) || (st.srcs[w].rs2_used && b2));
    end
    return exp_st;
  endfunction

  // Sets first, then clears, so a clear of the same register wins
  function automatic prf_pkg::prf_mask_t next_model(input step_t st);
    prf_pkg::prf_mask_t m;
    m = model_busy;
    if (st.flush) begin
      m = '0;
    end else begin
      for (int w = 0; w < WAYS; w++) begin
        if (st.set_req[w].valid && st.set_req[w].index != 0) begin
          m[st.set_req[w].index] = 1'b1;
        end
      end
      for (int w = 0; w < WAYS; w++) begin
        if (st.clr_req[w].valid) begin
          m[st.clr_req[w].index] = 1'b0;
        end
      end
    end
    return m;
  endfunction

  // Called on a falling edge, returns on the next one
  task automatic run_step(input step_t st, input string name, output bit ok);
    status_vec_t expected;
    ok      = 1'b1;
    set_req = st.set_req;
    clr_req = st.clr_req;
    flush   = st.flush;
    srcs    = st.srcs;
    #(CLK_PERIOD / 2 - 1);
    expected = expected_status(st);
    assert (status === expected) else begin
      $display("** Error: %s expected %b actual %b", name, expected, status);
      ok = 1'b0;
    end
    model_busy = next_model(st);
    @(negedge clk);
  endtask

  task automatic report_test(input string name, input bit ok);
    if (ok) begin
      n_pass++;
      $display("PASS  %s", name);
    end else begin
      n_fail++;
      $display("FAIL  %s", name);
    end
  endtask

  initial begin
    #((RST_CYCLES + N_DIRECTED + N_RANDOM + 50) * CLK_PERIOD);
    $display("Timeout: the test sequence did not finish in the expected time");
    $display("Testbench failed");
    $finish;
  end

  initial begin
    bit    ok;
    bit    random_ok;
    step_t st;
    set_req    = '0;
    clr_req    = '0;
    flush      = 1'b0;
    srcs       = '0;
    model_busy = '0;
    lfsr_state = LFSR_SEED;
    n_pass     = 0;
    n_fail     = 0;
    fill_table();
    do @(negedge clk); while (rst);

    for (int k = 0; k < N_DIRECTED; k++) begin
      run_step(step_table[k], step_name[k], ok);
      report_test(step_name[k], ok);
    end

    random_ok = 1'b1;
    for (int k = 0; k < N_RANDOM; k++) begin
      st = random_step();
      run_step(st, $sformatf("random_%0d", k), ok);
      random_ok = random_ok & ok;
    end
    report_test("random_mix", random_ok);

    // Bank checks bound into the scoreboard
    report_test("bank_assertions", DUT.u_scoreboard.u_assertions.fail_count == 0);

    $display("Tests passed: %0d, tests failed: %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
hw/prf_pkg.sv
hw/busy_update_decode.sv
hw/busy_scoreboard.sv
hw/operand_ready.sv
hw/busy_table_top.sv
testbench/tb_clock_gen.sv
testbench/busy_table_assertions.sv
testbench/busy_table_tb.sv
